// File: design/bus_defines.svh
// --------------------------------------------------
// Bus unit constants
// Word address map of the CPU bus and the default
// SPI and OS timer speeds
// --------------------------------------------------

`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// --------------------------------------------------
// Memory regions, end addresses are exclusive
// --------------------------------------------------
`define BUS_VRAM32_BASE 27'hC00000
`define BUS_VRAM32_END  27'hC00420
`define BUS_ROM_BASE    27'hC02522
`define BUS_ROM_END     27'hC02722

// --------------------------------------------------
// Single word I/O registers
// --------------------------------------------------
`define BUS_SPI_DATA    27'hC02728
`define BUS_SPI_CS      27'hC02729
`define BUS_GPIO        27'hC02737
`define BUS_OST_VALUE   27'hC02739
`define BUS_OST_TRIGGER 27'hC0273A
`define BUS_BOOT_MODE   27'hC02741

// Peripheral speeds in system clocks
`define SPI_CLKS_PER_HALF_BIT 2
`define OST_PRESCALE          4

`endif

// File: design/bus_pkg.sv
// --------------------------------------------------
// CPU bus types
// Address and data words plus the decoded region
// --------------------------------------------------
`default_nettype none

package bus_pkg;

    // Word addressed, 27 bits wide
    typedef logic [26:0] bus_addr_t;
    typedef logic [31:0] bus_word_t;

    // Offsets into the memory ports
    typedef logic [13:0] vram_addr_t;
    typedef logic [8:0]  rom_addr_t;

    // Target of the current bus address
    typedef enum logic [3:0]
    {
        VRAM32,
        ROM,
        SPI_DATA,
        SPI_CS,
        GPIO,
        OST_VALUE,
        OST_TRIGGER,
        BOOT_MODE,
        NONE
    } bus_region_t;

endpackage

`default_nettype wire

// File: design/periph_pkg.sv
// --------------------------------------------------
// Peripheral data types
// SPI byte, timer load value and GPIO nibble
// --------------------------------------------------
`default_nettype none

package periph_pkg;

    // One SPI transfer
    typedef logic [7:0] spi_byte_t;

    // Timer ticks before the interrupt
    typedef logic [31:0] ost_count_t;

    // Four GPI pins or four GPO pins
    typedef logic [3:0] gpio_nibble_t;

endpackage

`default_nettype wire

// File: design/spi_if.sv
// --------------------------------------------------
// SPI byte link
// Start and done pulses between decoder and master
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

interface spi_if;

    logic                  start;
    periph_pkg::spi_byte_t tx_byte;
    logic                  done;
    periph_pkg::spi_byte_t rx_byte;

    // Bus side, issues the transfer
    modport ctrl (output start, output tx_byte, input done, input rx_byte);

    // Master side, runs the transfer
    modport periph (input start, input tx_byte, output done, output rx_byte);

endinterface

`default_nettype wire

// File: design/spi_master.sv
// --------------------------------------------------
// SPI master
// Mode 0, one byte per transfer, MSB first
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "bus_defines.svh"

module spi_master
#(
    parameter int CLKS_PER_HALF_BIT = `SPI_CLKS_PER_HALF_BIT
)
(
    input  wire  clk,
    input  wire  reset,
    spi_if.periph spi,
    output logic o_spi_clk,
    output logic o_spi_mosi,
    input  wire  i_spi_miso
);

    localparam int DIV_W = (CLKS_PER_HALF_BIT > 1) ? $clog2(CLKS_PER_HALF_BIT) : 1;

    logic [DIV_W-1:0]      div_cnt;
    logic [3:0]            edge_cnt;
    logic                  busy;
    logic                  half_tick;
    periph_pkg::spi_byte_t tx_sr;
    periph_pkg::spi_byte_t rx_sr;

    assign half_tick = (div_cnt == DIV_W'(CLKS_PER_HALF_BIT - 1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy        <= 1'b0;
            div_cnt     <= '0;
            edge_cnt    <= '0;
            o_spi_clk   <= 1'b0;
            o_spi_mosi  <= 1'b0;
            spi.done    <= 1'b0;
            spi.rx_byte <= '0;
        end
        else
        begin
            spi.done <= 1'b0;
            if (!busy)
            begin
                // First bit goes out before the first rising edge
                if (spi.start)
                begin
                    busy       <= 1'b1;
                    div_cnt    <= '0;
                    edge_cnt   <= '0;
                    tx_sr      <= spi.tx_byte;
                    o_spi_mosi <= spi.tx_byte[7];
                end
            end
            else if (half_tick)
            begin
                div_cnt   <= '0;
                edge_cnt  <= edge_cnt + 4'd1;
                o_spi_clk <= ~o_spi_clk;
                if (!o_spi_clk)
                begin
                    rx_sr <= {rx_sr[6:0], i_spi_miso};
                end
                else
                begin
                    o_spi_mosi <= tx_sr[6];
                    tx_sr      <= {tx_sr[6:0], 1'b0};
                end
                // Sixteenth edge is the last falling one
                if (edge_cnt == 4'd15)
                begin
                    busy        <= 1'b0;
                    spi.done    <= 1'b1;
                    spi.rx_byte <= rx_sr;
                end
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/os_timer.sv
// --------------------------------------------------
// OS timer
// Prescaled countdown with a one-cycle interrupt
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "bus_defines.svh"

module os_timer
#(
    parameter int PRESCALE = `OST_PRESCALE
)
(
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    i_load,
    input  wire periph_pkg::ost_count_t i_value,
    input  wire                    i_trigger,
    output logic                   o_int
);

    localparam int PRE_W = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

    periph_pkg::ost_count_t load_q;
    periph_pkg::ost_count_t count;
    logic [PRE_W-1:0]       pre_cnt;
    logic                   running;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            load_q  <= '0;
            count   <= '0;
            pre_cnt <= '0;
            running <= 1'b0;
            o_int   <= 1'b0;
        end
        else
        begin
            o_int <= 1'b0;
            if (i_load)
            begin
                load_q <= i_value;
            end

            if (i_trigger)
            begin
                count   <= load_q;
                pre_cnt <= PRE_W'(PRESCALE - 1);
                running <= 1'b1;
            end
            else if (running)
            begin
                if (count == '0)
                begin
                    running <= 1'b0;
                    o_int   <= 1'b1;
                end
                else if (pre_cnt != '0)
                begin
                    pre_cnt <= pre_cnt - 1'b1;
                end
                else
                begin
                    // One tick every PRESCALE clocks
                    pre_cnt <= PRE_W'(PRESCALE - 1);
                    count   <= count - 1'b1;
                    if (count == 32'd1)
                    begin
                        running <= 1'b0;
                        o_int   <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/bus_decoder.sv
// --------------------------------------------------
// Bus decoder
// Address decode, completion timing, read data and
// the chip-select and GPO registers
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "bus_defines.svh"

module bus_decoder
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire bus_pkg::bus_addr_t  i_bus_addr,
    input  wire bus_pkg::bus_word_t  i_bus_data,
    input  wire                      i_bus_we,
    input  wire                      i_bus_start,
    output bus_pkg::bus_word_t       o_bus_q,
    output logic                     o_bus_done,
    output bus_pkg::vram_addr_t      o_vram32_addr,
    output bus_pkg::bus_word_t       o_vram32_d,
    output logic                     o_vram32_we,
    input  wire bus_pkg::bus_word_t  i_vram32_q,
    output bus_pkg::rom_addr_t       o_rom_addr,
    input  wire bus_pkg::bus_word_t  i_rom_q,
    input  wire periph_pkg::gpio_nibble_t i_gpi,
    output periph_pkg::gpio_nibble_t o_gpo,
    output logic                     o_spi_cs,
    input  wire                      i_boot_mode,
    spi_if.ctrl                      spi,
    output logic                     o_ost_load,
    output periph_pkg::ost_count_t   o_ost_value,
    output logic                     o_ost_trigger
);

    bus_pkg::bus_region_t region;
    bus_pkg::bus_addr_t   addr_q;
    bus_pkg::bus_addr_t   vram_off;
    bus_pkg::bus_addr_t   rom_off;
    bus_pkg::bus_word_t   data_q;
    bus_pkg::bus_word_t   read_word;
    logic                 served;
    logic                 done_next;
    logic                 spi_wait;
    logic                 accept;
    logic                 fast_path;
    logic                 spi_write;
    logic                 finish;

    // --------------------------------------------------
    // Region decode
    // --------------------------------------------------
    always_comb
    begin
        if (i_bus_addr >= `BUS_VRAM32_BASE && i_bus_addr < `BUS_VRAM32_END)
            region = bus_pkg::VRAM32;
        else if (i_bus_addr >= `BUS_ROM_BASE && i_bus_addr < `BUS_ROM_END)
            region = bus_pkg::ROM;
        else if (i_bus_addr == `BUS_SPI_DATA)
            region = bus_pkg::SPI_DATA;
        else if (i_bus_addr == `BUS_SPI_CS)
            region = bus_pkg::SPI_CS;
        else if (i_bus_addr == `BUS_GPIO)
            region = bus_pkg::GPIO;
        else if (i_bus_addr == `BUS_OST_VALUE)
            region = bus_pkg::OST_VALUE;
        else if (i_bus_addr == `BUS_OST_TRIGGER)
            region = bus_pkg::OST_TRIGGER;
        else if (i_bus_addr == `BUS_BOOT_MODE)
            region = bus_pkg::BOOT_MODE;
        else
            region = bus_pkg::NONE;
    end

    // VRAM32 port runs one cycle behind the bus on latched address and data
    assign vram_off      = addr_q - `BUS_VRAM32_BASE;
    assign rom_off       = i_bus_addr - `BUS_ROM_BASE;
    assign o_vram32_addr = vram_off[13:0];
    assign o_vram32_d    = data_q;
    assign o_rom_addr    = rom_off[8:0];

    // --------------------------------------------------
    // Completion sequencing
    // --------------------------------------------------
    assign accept    = i_bus_start && !served;
    assign fast_path = (region == bus_pkg::ROM) || (region == bus_pkg::VRAM32 && i_bus_we);
    assign spi_write = (region == bus_pkg::SPI_DATA) && i_bus_we;
    assign finish    = (accept && fast_path) || done_next || (spi_wait && spi.done);

    always_comb
    begin
        case (region)
            bus_pkg::VRAM32:    read_word = i_vram32_q;
            bus_pkg::ROM:       read_word = i_rom_q;
            bus_pkg::SPI_DATA:  read_word = {24'd0, spi.rx_byte};
            bus_pkg::SPI_CS:    read_word = {31'd0, o_spi_cs};
            bus_pkg::GPIO:      read_word = {24'd0, o_gpo, i_gpi};
            bus_pkg::BOOT_MODE: read_word = {31'd0, i_boot_mode};
            default:            read_word = '0;
        endcase
    end

    // Data path latches
    always_ff @(posedge clk)
    begin
        addr_q <= i_bus_addr;
        data_q <= i_bus_data;
        if (finish)
            o_bus_q <= read_word;
        if (accept && spi_write)
            spi.tx_byte <= i_bus_data[7:0];
        if (accept && region == bus_pkg::OST_VALUE && i_bus_we)
            o_ost_value <= i_bus_data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            o_bus_done    <= 1'b0;
            done_next     <= 1'b0;
            served        <= 1'b0;
            spi_wait      <= 1'b0;
            o_vram32_we   <= 1'b0;
            spi.start     <= 1'b0;
            o_ost_load    <= 1'b0;
            o_ost_trigger <= 1'b0;
            o_spi_cs      <= 1'b1;
            o_gpo         <= '0;
        end
        else
        begin
            o_bus_done    <= finish;
            done_next     <= accept && !fast_path && !spi_write;
            o_vram32_we   <= accept && region == bus_pkg::VRAM32 && i_bus_we;
            spi.start     <= accept && spi_write;
            o_ost_load    <= accept && region == bus_pkg::OST_VALUE && i_bus_we;
            o_ost_trigger <= accept && region == bus_pkg::OST_TRIGGER && i_bus_we;

            // Held start must not complete twice
            if (accept)
                served <= 1'b1;
            else if (!i_bus_start)
                served <= 1'b0;

            // SPI write waits for the end of the transfer
            if (accept && spi_write)
                spi_wait <= 1'b1;
            else if (spi.done)
                spi_wait <= 1'b0;

            if (accept && i_bus_we && region == bus_pkg::SPI_CS)
                o_spi_cs <= i_bus_data[0];
            if (accept && i_bus_we && region == bus_pkg::GPIO)
                o_gpo <= i_bus_data[7:4];
        end
    end

endmodule

`default_nettype wire

// File: design/memory_unit.sv
// --------------------------------------------------
// Memory unit
// CPU bus to VRAM32, boot ROM, SPI, OS timer, GPIO
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module memory_unit
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire bus_pkg::bus_addr_t  i_bus_addr,
    input  wire bus_pkg::bus_word_t  i_bus_data,
    input  wire                      i_bus_we,
    input  wire                      i_bus_start,
    output bus_pkg::bus_word_t       o_bus_q,
    output logic                     o_bus_done,
    output bus_pkg::vram_addr_t      o_vram32_addr,
    output bus_pkg::bus_word_t       o_vram32_d,
    output logic                     o_vram32_we,
    input  wire bus_pkg::bus_word_t  i_vram32_q,
    output bus_pkg::rom_addr_t       o_rom_addr,
    input  wire bus_pkg::bus_word_t  i_rom_q,
    output logic                     o_spi_clk,
    output logic                     o_spi_mosi,
    output logic                     o_spi_cs,
    input  wire                      i_spi_miso,
    input  wire periph_pkg::gpio_nibble_t i_gpi,
    output periph_pkg::gpio_nibble_t o_gpo,
    output logic                     o_ost_int,
    input  wire                      i_boot_mode
);

    // Decoder to timer
    logic                   ost_load;
    logic                   ost_trigger;
    periph_pkg::ost_count_t ost_value;

    spi_if spi ();

    bus_decoder u_decoder
    (
        .clk           (clk),
        .reset         (reset),
        .i_bus_addr    (i_bus_addr),
        .i_bus_data    (i_bus_data),
        .i_bus_we      (i_bus_we),
        .i_bus_start   (i_bus_start),
        .o_bus_q       (o_bus_q),
        .o_bus_done    (o_bus_done),
        .o_vram32_addr (o_vram32_addr),
        .o_vram32_d    (o_vram32_d),
        .o_vram32_we   (o_vram32_we),
        .i_vram32_q    (i_vram32_q),
        .o_rom_addr    (o_rom_addr),
        .i_rom_q       (i_rom_q),
        .i_gpi         (i_gpi),
        .o_gpo         (o_gpo),
        .o_spi_cs      (o_spi_cs),
        .i_boot_mode   (i_boot_mode),
        .spi           (spi.ctrl),
        .o_ost_load    (ost_load),
        .o_ost_value   (ost_value),
        .o_ost_trigger (ost_trigger)
    );

    spi_master u_spi
    (
        .clk        (clk),
        .reset      (reset),
        .spi        (spi.periph),
        .o_spi_clk  (o_spi_clk),
        .o_spi_mosi (o_spi_mosi),
        .i_spi_miso (i_spi_miso)
    );

    os_timer u_ost
    (
        .clk       (clk),
        .reset     (reset),
        .i_load    (ost_load),
        .i_value   (ost_value),
        .i_trigger (ost_trigger),
        .o_int     (o_ost_int)
    );

endmodule

`default_nettype wire

// File: bench/memory_unit_chk.sv
// --------------------------------------------------
// Memory unit checker
// Pulse rules for bus done, timer interrupt and
// the chip select after reset
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module memory_unit_chk
(
    input wire clk,
    input wire reset,
    input wire i_bus_start,
    input wire i_bus_done,
    input wire i_ost_int,
    input wire i_spi_cs
);

    // One done pulse per request
    done_single_cycle: assert property (@(posedge clk) disable iff (reset)
        i_bus_done |=> !i_bus_done)
        else $error("o_bus_done stayed high for two cycles");

    done_after_start: assert property (@(posedge clk) disable iff (reset)
        i_bus_done |-> $past(i_bus_start))
        else $error("o_bus_done rose without a request in the previous cycle");

    int_single_cycle: assert property (@(posedge clk) disable iff (reset)
        i_ost_int |=> !i_ost_int)
        else $error("o_ost_int stayed high for two cycles");

    // Deselected once reset has been seen
    cs_high_after_reset: assert property (@(posedge clk)
        reset |=> i_spi_cs)
        else $error("o_spi_cs not high one cycle after reset");

endmodule

bind memory_unit memory_unit_chk u_chk
(
    .clk         (clk),
    .reset       (reset),
    .i_bus_start (i_bus_start),
    .i_bus_done  (o_bus_done),
    .i_ost_int   (o_ost_int),
    .i_spi_cs    (o_spi_cs)
);

`default_nettype wire

// File: bench/memory_unit_tb.sv
// --------------------------------------------------
// Memory unit testbench
// Replays bus transactions from a stimulus file
// against VRAM32 and ROM models, SPI in loopback
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "bus_defines.svh"

module memory_unit_tb;

    localparam int VRAM_WORDS  = 1056;
    localparam int BUS_TIMEOUT = 200;
    localparam int INT_MARGIN  = 64;

    logic                     clk;
    logic                     reset;
    bus_pkg::bus_addr_t       bus_addr;
    bus_pkg::bus_word_t       bus_data;
    logic                     bus_we;
    logic                     bus_start;
    bus_pkg::bus_word_t       bus_q;
    logic                     bus_done;
    bus_pkg::vram_addr_t      vram32_addr;
    bus_pkg::bus_word_t       vram32_d;
    logic                     vram32_we;
    bus_pkg::bus_word_t       vram32_q;
    bus_pkg::rom_addr_t       rom_addr;
    bus_pkg::bus_word_t       rom_q;
    logic                     spi_clk;
    logic                     spi_mosi;
    logic                     spi_cs;
    periph_pkg::gpio_nibble_t gpi;
    periph_pkg::gpio_nibble_t gpo;
    logic                     ost_int;
    logic                     boot_mode;

    bus_pkg::bus_word_t       vram [VRAM_WORDS];

    always #4 clk = ~clk;

    // MOSI looped back to MISO
    memory_unit u_dut
    (
        .clk           (clk),
        .reset         (reset),
        .i_bus_addr    (bus_addr),
        .i_bus_data    (bus_data),
        .i_bus_we      (bus_we),
        .i_bus_start   (bus_start),
        .o_bus_q       (bus_q),
        .o_bus_done    (bus_done),
        .o_vram32_addr (vram32_addr),
        .o_vram32_d    (vram32_d),
        .o_vram32_we   (vram32_we),
        .i_vram32_q    (vram32_q),
        .o_rom_addr    (rom_addr),
        .i_rom_q       (rom_q),
        .o_spi_clk     (spi_clk),
        .o_spi_mosi    (spi_mosi),
        .o_spi_cs      (spi_cs),
        .i_spi_miso    (spi_mosi),
        .i_gpi         (gpi),
        .o_gpo         (gpo),
        .o_ost_int     (ost_int),
        .i_boot_mode   (boot_mode)
    );

    // --------------------------------------------------
    // Memory models
    // --------------------------------------------------
    function automatic bus_pkg::bus_word_t rom_word(input bus_pkg::rom_addr_t off);
        return {7'd0, off, 7'd0, off};
    endfunction

    assign rom_q    = rom_word(rom_addr);
    assign vram32_q = (vram32_addr < 14'(VRAM_WORDS)) ? vram[vram32_addr[10:0]] : '0;

    always @(posedge clk)
    begin
        if (vram32_we && vram32_addr < 14'(VRAM_WORDS))
            vram[vram32_addr[10:0]] <= vram32_d;
    end

    // --------------------------------------------------
    // Failure reporting
    // --------------------------------------------------
    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic abort_run(input string reason);
        $display("Error: %s", reason);
        $display("** FAIL **");
        $fatal(1);
    endtask

    // Cycles from start to done as the bus timing rules give them
    function automatic int expected_latency(input logic we, input bus_pkg::bus_addr_t addr);
        logic in_vram;
        logic in_rom;
        in_vram = (addr >= `BUS_VRAM32_BASE) && (addr < `BUS_VRAM32_END);
        in_rom  = (addr >= `BUS_ROM_BASE) && (addr < `BUS_ROM_END);
        if ((in_vram && we) || (in_rom && !we))
            return 1;
        return 2;
    endfunction

    // One request, held until done
    task automatic bus_access(input logic we, input bus_pkg::bus_addr_t addr,
                              input bus_pkg::bus_word_t data, output int latency);
        int waited;
        @(negedge clk);
        assert (bus_done == 1'b0)
            else abort_run("o_bus_done was high before the request was issued");
        bus_addr  = addr;
        bus_data  = data;
        bus_we    = we;
        bus_start = 1'b1;
        waited    = 0;
        while (!bus_done && waited < BUS_TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        assert (bus_done)
            else abort_run("timeout waiting for o_bus_done");
        bus_start = 1'b0;
        bus_we    = 1'b0;
        latency   = waited;
    endtask

    task automatic latency_check(input logic we, input bus_pkg::bus_addr_t addr,
                                 input int latency);
        if (we && addr == `BUS_SPI_DATA)
        begin
            assert (latency > 16 * `SPI_CLKS_PER_HALF_BIT)
                else abort_run("SPI data write completed before the transfer ended");
        end
        else
        begin
            assert (latency == expected_latency(we, addr))
                else value_mismatch("o_bus_done latency", latency, expected_latency(we, addr));
        end
    endtask

    task automatic write_side_effects(input bus_pkg::bus_addr_t addr,
                                      input bus_pkg::bus_word_t wdata);
        if (addr == `BUS_SPI_CS)
        begin
            assert (spi_cs == wdata[0])
                else value_mismatch("o_spi_cs", 32'(spi_cs), 32'(wdata[0]));
        end
        if (addr == `BUS_GPIO)
        begin
            assert (gpo == wdata[7:4])
                else value_mismatch("o_gpo", 32'(gpo), 32'(wdata[7:4]));
        end
        if (addr == `BUS_SPI_DATA)
        begin
            assert (spi_clk == 1'b0)
                else value_mismatch("o_spi_clk", 32'(spi_clk), 32'd0);
        end
    endtask

    task automatic post_reset_outputs();
        assert (bus_done == 1'b0) else value_mismatch("o_bus_done", 32'(bus_done), 32'd0);
        assert (spi_cs == 1'b1) else value_mismatch("o_spi_cs", 32'(spi_cs), 32'd1);
        assert (gpo == 4'd0) else value_mismatch("o_gpo", 32'(gpo), 32'd0);
        assert (spi_clk == 1'b0) else value_mismatch("o_spi_clk", 32'(spi_clk), 32'd0);
        assert (ost_int == 1'b0) else value_mismatch("o_ost_int", 32'(ost_int), 32'd0);
        assert (vram32_we == 1'b0) else value_mismatch("o_vram32_we", 32'(vram32_we), 32'd0);
    endtask

    // Interrupt no sooner than prescale times value, then silence
    task automatic wait_ost_interrupt(input int value);
        int cycles;
        int limit;
        int quiet;
        limit  = `OST_PRESCALE * value + INT_MARGIN;
        cycles = 0;
        while (!ost_int && cycles < limit)
        begin
            @(negedge clk);
            cycles++;
        end
        assert (ost_int)
            else abort_run("timeout waiting for o_ost_int");
        assert (cycles >= `OST_PRESCALE * value)
            else value_mismatch("o_ost_int delay", cycles, `OST_PRESCALE * value);
        quiet = 0;
        while (quiet < limit)
        begin
            @(negedge clk);
            quiet++;
            assert (!ost_int)
                else abort_run("o_ost_int pulsed again without a new trigger");
        end
    endtask

    // --------------------------------------------------
    // Stimulus file replay
    // --------------------------------------------------
    task automatic run_stimulus(output int count);
        int                       fd;
        int                       n;
        int                       fields;
        int                       latency;
        string                    line;
        logic [7:0]               op;
        bus_pkg::bus_addr_t       addr;
        bus_pkg::bus_word_t       wdata;
        bus_pkg::bus_word_t       expected;
        periph_pkg::gpio_nibble_t gpi_val;
        count = 0;
        fd    = $fopen("bench/memory_unit_stim.txt", "r");
        if (fd == 0)
            abort_run("cannot open bench/memory_unit_stim.txt");
        n = $fgets(line, fd);
        while (n != 0)
        begin
            op = line.getc(0);
            if (line.len() > 1 && op != "#")
            begin
                fields = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h",
                                 addr, wdata, gpi_val, expected);
                assert (fields == 4)
                    else abort_run("malformed line in the stimulus file");
                gpi = gpi_val;
                if (op == "W" || op == "R")
                begin
                    bus_access(op == "W", addr, wdata, latency);
                    latency_check(op == "W", addr, latency);
                    if (op == "R")
                    begin
                        assert (bus_q == expected)
                            else value_mismatch("o_bus_q", bus_q, expected);
                    end
                    else
                    begin
                        write_side_effects(addr, wdata);
                    end
                end
                else if (op == "I")
                begin
                    wait_ost_interrupt(int'(wdata));
                end
                else
                begin
                    abort_run("unknown operation in the stimulus file");
                end
                count++;
            end
            n = $fgets(line, fd);
        end
        $fclose(fd);
    endtask

    initial
    begin
        int count;
        clk       = 1'b0;
        reset     = 1'b1;
        bus_addr  = '0;
        bus_data  = '0;
        bus_we    = 1'b0;
        bus_start = 1'b0;
        gpi       = '0;
        boot_mode = 1'b1;
        for (int i = 0; i < VRAM_WORDS; i++)
            vram[11'(i)] <= 32'h5A000000 | 32'(i);

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        post_reset_outputs();
        run_stimulus(count);

        if (count > 0)
        begin
            $display("** PASS **");
            $finish;
        end
        else
        begin
            $display("Error: the stimulus file held no transactions");
            $display("** FAIL **");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: bench/memory_unit_stim.txt
# Columns: op addr wdata gpi expected, all fields in hex
# W writes, R reads and compares, I waits for the timer interrupt of value wdata
R C00010 00000000 0 5A000010
W C00005 DEADBEEF 0 00000000
R C00005 00000000 0 DEADBEEF
W C0041F 12345678 0 00000000
R C0041F 00000000 0 12345678
R C02523 00000000 0 00010001
R C02721 00000000 0 01FF01FF
R 0000100 00000000 0 00000000
R BFFFFF 00000000 0 00000000
R C00420 00000000 0 00000000
R C02742 00000000 0 00000000
R 7FFFFFF 00000000 0 00000000
W 0000200 11111111 0 00000000
W C02729 00000000 0 00000000
R C02729 00000000 0 00000000
W C02728 000000A5 0 00000000
R C02728 00000000 0 000000A5
W C02728 0000003C 0 00000000
R C02728 00000000 0 0000003C
W C02729 00000001 0 00000000
R C02729 00000000 0 00000001
W C02737 000000A0 5 00000000
R C02737 00000000 C 000000AC
R C02741 00000000 0 00000001
W C02739 00000005 0 00000000
W C0273A 00000001 0 00000000
I 0000000 00000005 0 00000000
W C02739 00000002 0 00000000
W C0273A 00000001 0 00000000
I 0000000 00000002 0 00000000

// File: verilog.f
+incdir+design
design/bus_pkg.sv
design/periph_pkg.sv
design/spi_if.sv
design/spi_master.sv
design/os_timer.sv
design/bus_decoder.sv
design/memory_unit.sv
bench/memory_unit_chk.sv
bench/memory_unit_tb.sv

// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert
TOP        ?= memory_unit_tb
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Exit status of the simulation binary is the test result
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
